//--- design/ice51_isa_pkg.sv
`default_nettype none

package ice51_isa_pkg;

   localparam int          CODE_AW    = 8;
   localparam int          CODE_DEPTH = 256;        // bytes booted before the core runs
   localparam logic [15:0] TX_ADDR    = 16'h0201;   // movx target for the uart transmitter

   //////////////////////////////////////////////////////////////////////
   // opcodes

   localparam logic [7:0] LJMP    = 8'h02;   // ljmp addr16
   localparam logic [7:0] INC_A   = 8'h04;
   localparam logic [7:0] RRC_A   = 8'h13;
   localparam logic [7:0] DEC_A   = 8'h14;
   localparam logic [7:0] RL_A    = 8'h23;
   localparam logic [7:0] ADD_AI  = 8'h24;
   localparam logic [7:0] RLC_A   = 8'h33;
   localparam logic [7:0] ADDC_AI = 8'h34;
   localparam logic [7:0] JC      = 8'h40;
   localparam logic [7:0] ORL_AI  = 8'h44;
   localparam logic [7:0] JNC     = 8'h50;
   localparam logic [7:0] ANL_AI  = 8'h54;
   localparam logic [7:0] JZ      = 8'h60;
   localparam logic [7:0] XRL_AI  = 8'h64;
   localparam logic [7:0] JNZ     = 8'h70;
   localparam logic [7:0] MOV_AI  = 8'h74;
   localparam logic [7:0] SJMP    = 8'h80;
   localparam logic [7:0] MOV_DP  = 8'h90;   // mov dptr,#hi,lo
   localparam logic [7:0] SUBB_AI = 8'h94;
   localparam logic [7:0] CLR_C   = 8'hC3;
   localparam logic [7:0] SETB_C  = 8'hD3;
   localparam logic [7:0] CLR_A   = 8'hE4;
   localparam logic [7:0] MOVX_DA = 8'hF0;   // movx @dptr,a
   localparam logic [7:0] CPL_A   = 8'hF4;

   //////////////////////////////////////////////////////////////////////
   // sequencer and instruction types

   typedef enum logic [2:0] {
      FETCH,
      DECODE0,
      DECODE1,
      DECODE2,
      EXECUTE
   } seq_state_t;

   typedef struct packed {
      logic [7:0]         opcode;
      logic [7:0]         op1;       // first operand byte
      logic [7:0]         op2;       // second operand byte
      logic [CODE_AW-1:0] next_pc;   // address after the instruction
   } instr_t;

   typedef struct packed {
      logic               load;
      logic [CODE_AW-1:0] target;
   } pc_load_t;

endpackage

`default_nettype wire

//--- design/ice51_uart_pkg.sv
`default_nettype none

package ice51_uart_pkg;

   localparam int CLKS_PER_BIT = 16;   // short bit time for simulation
   localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } uart_byte_t;

   // frame machines
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

//--- design/ice51_uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module ice51_uart_rx import ice51_uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   output uart_byte_t o_byte
);

   logic [1:0]           rx_sync;
   logic                 rx_s;
   rx_state_t            state;
   logic [BIT_CNT_W-1:0] cnt;
   logic [2:0]           bit_idx;
   logic [7:0]           shreg;
   logic                 valid;
   logic                 half_hit;
   logic                 full_hit;

   assign rx_s     = rx_sync[1];
   assign half_hit = (cnt == BIT_CNT_W'(CLKS_PER_BIT/2 - 1));   // middle of start bit
   assign full_hit = (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

   // two-flop resync, idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_sync <= 2'b11;
      else         rx_sync <= {rx_sync[0], i_rx};
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         valid   <= 1'b0;
      end else begin
         valid <= 1'b0;
         cnt   <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_s) state <= RX_START;   // falling edge
            end
            RX_START: if (half_hit) begin
               cnt     <= '0;
               bit_idx <= '0;
               state   <= rx_s ? RX_IDLE : RX_DATA;   // glitch goes back to idle
            end
            RX_DATA: if (full_hit) begin
               cnt     <= '0;
               bit_idx <= bit_idx + 1'b1;
               if (bit_idx == 3'd7) state <= RX_STOP;
            end
            RX_STOP: if (full_hit) begin
               valid <= 1'b1;   // one pulse per frame
               state <= RX_IDLE;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb arrives first
   always_ff @(posedge i_clk) begin
      if (state == RX_DATA && full_hit) shreg <= {rx_s, shreg[7:1]};
   end

   assign o_byte = '{valid: valid, data: shreg};

endmodule

`default_nettype wire

//--- design/ice51_uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module ice51_uart_tx import ice51_uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  uart_byte_t i_req,
   output logic       o_ready,
   output logic       o_tx
);

   tx_state_t            state;
   logic [BIT_CNT_W-1:0] cnt;
   logic [2:0]           bit_idx;
   logic [7:0]           shreg;
   logic                 accept;
   logic                 bit_end;

   assign o_ready = (state == TX_IDLE);
   assign accept  = i_req.valid & o_ready;
   assign bit_end = (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
         case (state)
            TX_IDLE: if (accept) state <= TX_START;
            TX_START: if (bit_end) begin
               bit_idx <= '0;
               state   <= TX_DATA;
            end
            TX_DATA: if (bit_end) begin
               bit_idx <= bit_idx + 1'b1;
               if (bit_idx == 3'd7) state <= TX_STOP;
            end
            TX_STOP: if (bit_end) state <= TX_IDLE;   // ready again after stop bit
            default: state <= TX_IDLE;
         endcase
      end
   end

   // byte latched on handshake, shifted out lsb first
   always_ff @(posedge i_clk) begin
      if (accept)                          shreg <= i_req.data;
      else if (state == TX_DATA && bit_end) shreg <= {1'b0, shreg[7:1]};
   end

   always_comb begin
      case (state)
         TX_START: o_tx = 1'b0;
         TX_DATA:  o_tx = shreg[0];
         default:  o_tx = 1'b1;   // idle and stop
      endcase
   end

endmodule

`default_nettype wire

//--- design/ice51_code_mem.sv
`timescale 1ns/10ps
`default_nettype none

module ice51_code_mem import ice51_isa_pkg::*, ice51_uart_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  uart_byte_t         i_rx_byte,
   input  logic [CODE_AW-1:0] i_fetch_addr,
   output logic [7:0]         o_code_data,
   output logic               o_boot_done
);

   logic [7:0]         mem [CODE_DEPTH];
   logic [CODE_AW-1:0] load_addr;
   logic               load_wr;

   // bytes are only taken while booting
   assign load_wr = i_rx_byte.valid & ~o_boot_done;

   //////////////////////////////////////////////////////////////////////
   // boot loader

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         load_addr   <= '0;
         o_boot_done <= 1'b0;
      end else if (load_wr) begin
         load_addr <= load_addr + 1'b1;
         if (load_addr == CODE_AW'(CODE_DEPTH - 1)) o_boot_done <= 1'b1;   // sticky
      end
   end

   //////////////////////////////////////////////////////////////////////
   // ram

   always_ff @(posedge i_clk) begin
      if (load_wr) mem[load_addr] <= i_rx_byte.data;
      o_code_data <= mem[i_fetch_addr];   // data one cycle after the address
   end

endmodule

`default_nettype wire

//--- design/ice51_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module ice51_fetch import ice51_isa_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_boot_done,
   input  logic [7:0]         i_code_data,
   output logic [CODE_AW-1:0] o_code_addr,
   output instr_t             o_instr,
   output logic               o_instr_valid,
   input  logic               i_exec_done,
   input  pc_load_t           i_pc_load
);

   seq_state_t         state;
   seq_state_t         state_nxt;
   logic [CODE_AW-1:0] pc;
   logic [7:0]         opcode;
   logic [7:0]         op1;
   logic [7:0]         op2;
   logic [1:0]         len_now;    // from the opcode on the read bus
   logic [1:0]         len_held;   // from the latched opcode
   logic               pc_step;

   // bytes per instruction
   function automatic logic [1:0] instr_len(input logic [7:0] opc);
      case (opc)
         LJMP, MOV_DP: instr_len = 2'd3;
         MOV_AI, ADD_AI, ADDC_AI, SUBB_AI, ANL_AI, ORL_AI, XRL_AI,
         SJMP, JZ, JNZ, JC, JNC: instr_len = 2'd2;
         default: instr_len = 2'd1;
      endcase
   endfunction

   assign len_now  = instr_len(i_code_data);
   assign len_held = instr_len(opcode);

   //////////////////////////////////////////////////////////////////////
   // sequencer

   always_comb begin
      state_nxt = state;
      case (state)
         FETCH:   if (i_boot_done) state_nxt = DECODE0;
         DECODE0: state_nxt = (len_now == 2'd1) ? EXECUTE : DECODE1;
         DECODE1: state_nxt = (len_held == 2'd3) ? DECODE2 : EXECUTE;
         DECODE2: state_nxt = EXECUTE;
         EXECUTE: if (i_exec_done) state_nxt = FETCH;
         default: state_nxt = FETCH;
      endcase
   end

   // one increment per byte read
   assign pc_step = (state == FETCH && i_boot_done) ||
                    (state == DECODE0 && len_now != 2'd1) ||
                    (state == DECODE1 && len_held == 2'd3);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= FETCH;
         pc    <= '0;
      end else begin
         state <= state_nxt;
         if (state == EXECUTE) begin
            if (i_exec_done && i_pc_load.load) pc <= i_pc_load.target;
         end else if (pc_step) begin
            pc <= pc + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == DECODE0) opcode <= i_code_data;
      if (state == DECODE1) op1 <= i_code_data;
      if (state == DECODE2) op2 <= i_code_data;
   end

   assign o_code_addr   = pc;
   assign o_instr       = '{opcode: opcode, op1: op1, op2: op2, next_pc: pc};
   assign o_instr_valid = (state == EXECUTE);

endmodule

`default_nettype wire

//--- design/ice51_exec.sv
`timescale 1ns/10ps
`default_nettype none

module ice51_exec import ice51_isa_pkg::*, ice51_uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  instr_t     i_instr,
   input  logic       i_instr_valid,
   output logic       o_exec_done,
   output pc_load_t   o_pc_load,
   output uart_byte_t o_tx_req,
   input  logic       i_tx_ready
);

   logic [7:0]         acc;
   logic               carry;
   logic [15:0]        dptr;
   logic [7:0]         acc_nxt;
   logic               carry_nxt;
   logic [15:0]        dptr_nxt;
   logic [7:0]         imm;
   logic               cin;
   logic [8:0]         add9;
   logic [8:0]         sub9;   // bit 8 is the borrow
   logic               acc_zero;
   logic               taken;
   logic [CODE_AW-1:0] rel_target;
   logic               tx_sel;

   assign imm      = i_instr.op1;
   assign cin      = (i_instr.opcode == ADDC_AI) & carry;
   assign add9     = {1'b0, acc} + {1'b0, imm} + {8'd0, cin};
   assign sub9     = {1'b0, acc} - {1'b0, imm} - {8'd0, carry};
   assign acc_zero = (acc == 8'd0);

   //////////////////////////////////////////////////////////////////////
   // alu

   always_comb begin
      acc_nxt   = acc;
      carry_nxt = carry;
      dptr_nxt  = dptr;
      case (i_instr.opcode)
         INC_A:   acc_nxt = acc + 8'd1;   // carry untouched
         DEC_A:   acc_nxt = acc - 8'd1;
         CLR_A:   acc_nxt = 8'd0;
         CPL_A:   acc_nxt = ~acc;
         RL_A:    acc_nxt = {acc[6:0], acc[7]};
         RLC_A:   {carry_nxt, acc_nxt} = {acc, carry};
         RRC_A:   {acc_nxt, carry_nxt} = {carry, acc};
         CLR_C:   carry_nxt = 1'b0;
         SETB_C:  carry_nxt = 1'b1;
         MOV_AI:  acc_nxt = imm;
         ADD_AI, ADDC_AI: {carry_nxt, acc_nxt} = add9;
         SUBB_AI: {carry_nxt, acc_nxt} = sub9;
         ANL_AI:  acc_nxt = acc & imm;
         ORL_AI:  acc_nxt = acc | imm;
         XRL_AI:  acc_nxt = acc ^ imm;
         MOV_DP:  dptr_nxt = {i_instr.op1, i_instr.op2};   // high byte first
         default: acc_nxt = acc;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // branches

   always_comb begin
      case (i_instr.opcode)
         SJMP, LJMP: taken = 1'b1;
         JZ:         taken = acc_zero;
         JNZ:        taken = ~acc_zero;
         JC:         taken = carry;
         JNC:        taken = ~carry;
         default:    taken = 1'b0;
      endcase
   end

   // signed offset from the following instruction
   assign rel_target = i_instr.next_pc + CODE_AW'(signed'(i_instr.op1));

   assign o_pc_load.load   = i_instr_valid & taken;
   assign o_pc_load.target = (i_instr.opcode == LJMP) ? i_instr.op2[CODE_AW-1:0] : rel_target;

   //////////////////////////////////////////////////////////////////////
   // transmit request and completion

   assign tx_sel = (i_instr.opcode == MOVX_DA) && (dptr == TX_ADDR);

   assign o_tx_req    = '{valid: i_instr_valid & tx_sel, data: acc};
   assign o_exec_done = i_instr_valid & (~tx_sel | i_tx_ready);   // stall while tx busy

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else if (o_exec_done) begin
         acc   <= acc_nxt;
         carry <= carry_nxt;
         dptr  <= dptr_nxt;
      end
   end

endmodule

`default_nettype wire

//--- design/ice51_top.sv
`timescale 1ns/10ps
`default_nettype none

module ice51_top import ice51_isa_pkg::*, ice51_uart_pkg::*; (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx,
   output logic o_boot_done
);

   uart_byte_t         rx_byte;
   uart_byte_t         tx_req;
   logic               tx_ready;
   logic [CODE_AW-1:0] code_addr;
   logic [7:0]         code_data;
   instr_t             instr;
   logic               instr_valid;
   logic               exec_done;
   pc_load_t           pc_load;

   // serial in, boot ram, core, serial out
   ice51_uart_rx rx_i (.i_clk, .i_nrst, .i_rx(i_uart_rx), .o_byte(rx_byte));

   ice51_code_mem mem_i (.i_clk, .i_nrst, .i_rx_byte(rx_byte), .i_fetch_addr(code_addr),
                         .o_code_data(code_data), .o_boot_done);

   ice51_fetch fetch_i (.i_clk, .i_nrst, .i_boot_done(o_boot_done), .i_code_data(code_data),
                        .o_code_addr(code_addr), .o_instr(instr), .o_instr_valid(instr_valid),
                        .i_exec_done(exec_done), .i_pc_load(pc_load));

   ice51_exec exec_i (.i_clk, .i_nrst, .i_instr(instr), .i_instr_valid(instr_valid),
                      .o_exec_done(exec_done), .o_pc_load(pc_load), .o_tx_req(tx_req),
                      .i_tx_ready(tx_ready));

   ice51_uart_tx tx_i (.i_clk, .i_nrst, .i_req(tx_req), .o_ready(tx_ready), .o_tx(o_uart_tx));

endmodule

`default_nettype wire

//--- tb/ice51_properties.sv
`timescale 1ns/10ps
`default_nettype none

module ice51_properties (
   input wire logic i_clk,
   input wire logic i_nrst,
   input wire logic i_uart_tx,
   input wire logic i_boot_done
);

   // line stays idle while the code ram is still loading
   a_tx_idle_in_boot: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_boot_done |-> i_uart_tx)
      else $error("uart tx line left idle before boot was done");

   a_boot_done_sticky: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_boot_done |=> i_boot_done)
      else $error("boot done flag fell after it was set");

   a_tx_known: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !$isunknown(i_uart_tx))
      else $error("uart tx line is unknown after reset");

endmodule

bind ice51_top ice51_properties props_i (.i_clk(i_clk), .i_nrst(i_nrst),
                                         .i_uart_tx(o_uart_tx), .i_boot_done(o_boot_done));

`default_nettype wire

//--- tb/ice51_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ice51_tb import ice51_isa_pkg::*, ice51_uart_pkg::*; ();

   localparam logic [31:0] SEED        = 32'h9789_f949;
   localparam int          FRAME_CLKS  = 10 * CLKS_PER_BIT;
   localparam int          MODEL_STEPS = 4000;   // far beyond any generated program

   logic       clk;
   logic       nrst;
   logic       uart_rx;
   logic       uart_tx;
   logic       boot_done;
   logic [7:0] prog [CODE_DEPTH];
   logic [7:0] exp_q [$];   // bytes the model expects on tx
   logic [7:0] rx_q [$];    // bytes decoded from tx
   int         gen_pos;
   int         err_cnt;
   int         timeout_cnt;

   ice51_top dut_i (.i_clk(clk), .i_nrst(nrst), .i_uart_rx(uart_rx),
                    .o_uart_tx(uart_tx), .o_boot_done(boot_done));

   initial clk = 1'b0;
   always #4 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // checks

   task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %0t: %s got %02h expected %02h", $time, what, got, exp);
      end
   endtask

   task automatic compare_logic(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic compare_count(input int got, input int exp, input string what);
      if (got != exp) begin
         err_cnt++;
         $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // random program

   task automatic emit(input logic [7:0] b);
      prog[gen_pos] = b;
      gen_pos++;
   endtask

   task automatic gen_program();
      logic [7:0]  alu1 [9] = '{INC_A, DEC_A, CLR_A, CPL_A, RL_A, RLC_A, RRC_A, CLR_C, SETB_C};
      logic [7:0]  alu2 [7] = '{MOV_AI, ADD_AI, ADDC_AI, SUBB_AI, ANL_AI, ORL_AI, XRL_AI};
      logic [7:0]  jcc [5]  = '{JZ, JNZ, JC, JNC, SJMP};
      logic [15:0] dp;
      int          kind;
      int          items;
      int          gap;
      int          target;
      for (int a = 0; a < CODE_DEPTH; a++) prog[a] = 8'h00;   // zero padding
      gen_pos = 0;
      items   = 0;
      emit(MOV_DP);
      emit(TX_ADDR[15:8]);
      emit(TX_ADDR[7:0]);
      while (gen_pos < CODE_DEPTH - 16) begin
         kind = $urandom_range(0, 9);
         items++;
         if (items == 20) begin
            // ljmp over a gap of movx that must never run
            gap    = $urandom_range(1, 6);
            target = gen_pos + 3 + gap;
            emit(LJMP);
            emit(8'h00);
            emit(8'(target));
            repeat (gap) emit(MOVX_DA);
         end else if (kind <= 2) begin
            emit(alu1[$urandom_range(0, 8)]);
         end else if (kind <= 5) begin
            emit(alu2[$urandom_range(0, 6)]);
            emit(8'($urandom));
         end else if (kind == 6) begin
            dp = 16'($urandom);
            if (dp == TX_ADDR || $urandom_range(0, 2) != 0) dp = TX_ADDR;
            emit(MOV_DP);
            emit(dp[15:8]);
            emit(dp[7:0]);
         end else if (kind == 7) begin
            emit(MOVX_DA);
            if ($urandom_range(0, 1) == 1) emit(MOVX_DA);   // back to back
         end else begin
            emit(jcc[$urandom_range(0, 4)]);
            emit(8'h02);   // skip the next two-byte instruction
            emit(alu2[$urandom_range(0, 6)]);
            emit(8'($urandom));
            emit(MOVX_DA);
         end
      end
      emit(SJMP);
      emit(8'hFE);   // self loop
   endtask

   //////////////////////////////////////////////////////////////////////
   // isa model

   task automatic run_model();
      logic [7:0]  pc;
      logic [7:0]  nxt;
      logic [7:0]  len;
      logic [7:0]  acc;
      logic [7:0]  b1;
      logic [7:0]  b2;
      logic [8:0]  r;
      logic        c;
      logic [15:0] dp;
      int          steps;
      pc    = 8'd0;
      acc   = 8'd0;
      c     = 1'b0;
      dp    = 16'd0;
      steps = 0;
      while (!(prog[pc] == SJMP && prog[pc + 8'd1] == 8'hFE) && steps < MODEL_STEPS) begin
         b1 = prog[pc + 8'd1];
         b2 = prog[pc + 8'd2];
         case (prog[pc])
            LJMP, MOV_DP: len = 8'd3;
            MOV_AI, ADD_AI, ADDC_AI, SUBB_AI, ANL_AI, ORL_AI, XRL_AI,
            SJMP, JZ, JNZ, JC, JNC: len = 8'd2;
            default: len = 8'd1;
         endcase
         nxt = pc + len;
         pc  = nxt;
         case (prog[nxt - len])
            INC_A:   acc = acc + 8'd1;
            DEC_A:   acc = acc - 8'd1;
            CLR_A:   acc = 8'd0;
            CPL_A:   acc = ~acc;
            RL_A:    acc = {acc[6:0], acc[7]};
            RLC_A: begin
               r   = {acc, c};   // nine-bit ring through carry
               c   = r[8];
               acc = r[7:0];
            end
            RRC_A: begin
               r   = {c, acc};
               c   = r[0];
               acc = r[8:1];
            end
            CLR_C:   c = 1'b0;
            SETB_C:  c = 1'b1;
            MOV_AI:  acc = b1;
            ADD_AI: begin
               r   = {1'b0, acc} + {1'b0, b1};
               c   = r[8];
               acc = r[7:0];
            end
            ADDC_AI: begin
               r   = {1'b0, acc} + {1'b0, b1} + {8'd0, c};
               c   = r[8];
               acc = r[7:0];
            end
            SUBB_AI: begin
               r   = {1'b0, acc} - {1'b0, b1} - {8'd0, c};   // borrow in bit 8
               c   = r[8];
               acc = r[7:0];
            end
            ANL_AI:  acc = acc & b1;
            ORL_AI:  acc = acc | b1;
            XRL_AI:  acc = acc ^ b1;
            SJMP:    pc = nxt + b1;
            JZ:      if (acc == 8'd0) pc = nxt + b1;
            JNZ:     if (acc != 8'd0) pc = nxt + b1;
            JC:      if (c) pc = nxt + b1;
            JNC:     if (!c) pc = nxt + b1;
            LJMP:    pc = b2;
            MOV_DP:  dp = {b1, b2};
            MOVX_DA: if (dp == TX_ADDR) exp_q.push_back(acc);
            default: ;
         endcase
         steps++;
      end
      if (steps >= MODEL_STEPS) begin
         err_cnt++;
         $display("model never reached the self loop of the generated program");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // serial driver and monitor

   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};   // stop, data, start
      for (int i = 0; i < 10; i++) begin
         uart_rx = frame[i];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
   endtask

   task automatic receive_frame();
      logic [7:0] b;
      repeat (CLKS_PER_BIT / 2) @(negedge clk);   // middle of start bit
      if (uart_tx !== 1'b0) begin
         err_cnt++;
         $display("start bit on the uart tx line did not stay low");
      end
      for (int i = 0; i < 8; i++) begin
         repeat (CLKS_PER_BIT) @(negedge clk);
         b[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_tx !== 1'b1) begin
         err_cnt++;
         $display("stop bit missing on the uart tx line");
      end
      if (rx_q.size() < exp_q.size()) begin
         compare_byte(b, exp_q[rx_q.size()], $sformatf("tx byte %0d", rx_q.size()));
      end
      rx_q.push_back(b);
   endtask

   always begin
      @(negedge clk);
      if (nrst === 1'b1 && uart_tx === 1'b0) receive_frame();
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      int wait_cnt;
      int limit;
      nrst        = 1'b0;
      uart_rx     = 1'b1;
      err_cnt     = 0;
      timeout_cnt = 0;
      void'($urandom(SEED));
      gen_program();
      run_model();
      repeat (5) @(negedge clk);
      nrst = 1'b1;
      @(negedge clk);
      compare_logic(boot_done, 1'b0, "boot done after reset");
      compare_logic(uart_tx, 1'b1, "tx line after reset");
      for (int a = 0; a < CODE_DEPTH; a++) begin
         if (a == CODE_DEPTH - 1) compare_logic(boot_done, 1'b0, "boot done before last byte");
         send_byte(prog[a]);
      end
      wait_cnt = 0;
      while (boot_done !== 1'b1 && wait_cnt < FRAME_CLKS) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (boot_done !== 1'b1) begin
         timeout_cnt++;
         $display("boot done never rose after all code bytes were sent");
      end else begin
         wait_cnt = 0;
         limit    = FRAME_CLKS * (exp_q.size() + 4) + 4096;
         while (rx_q.size() < exp_q.size() && wait_cnt < limit) begin
            @(negedge clk);
            wait_cnt++;
         end
         if (rx_q.size() < exp_q.size()) begin
            timeout_cnt++;
            $display("timed out waiting for the expected transmitted bytes");
         end
         // line stays quiet once the self loop is reached
         wait_cnt = 0;
         while (wait_cnt < 5 * FRAME_CLKS) begin
            @(negedge clk);
            wait_cnt++;
         end
         compare_count(rx_q.size(), exp_q.size(), "transmitted byte count");
      end
      $display("errors %0d, timeouts %0d", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
design/ice51_isa_pkg.sv
design/ice51_uart_pkg.sv
design/ice51_uart_rx.sv
design/ice51_uart_tx.sv
design/ice51_code_mem.sv
design/ice51_fetch.sv
design/ice51_exec.sv
design/ice51_top.sv
tb/ice51_properties.sv
tb/ice51_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ice51 testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module ice51_tb -o ice51_sim

./obj_dir/ice51_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
   exit 0
fi
exit 1
